/* vlog.f */
hdl/subsys_pkg.sv
hdl/map_cfg_regs.sv
hdl/addr_decoder.sv
hdl/debug_holdoff.sv
hdl/rtc_timebase.sv
hdl/soc_ctrl_top.sv
testbench/soc_ctrl_props.sv
testbench/soc_ctrl_tb.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module soc_ctrl_tb

sim:
	verilator --binary --timing --assert -f vlog.f --top-module soc_ctrl_tb -o soc_ctrl_sim
	./obj_dir/soc_ctrl_sim 2>&1 | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "TESTS PASSED" sim.log || (echo "Simulation ended without a verdict"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* testbench/soc_ctrl_tb.sv */
module soc_ctrl_tb;

  localparam int unsigned ClkPeriod     = 100;
  localparam int unsigned ResetCycles   = 8;
  localparam int unsigned NumHarts      = 2;
  localparam int unsigned HoldOffCycles = 20;
  localparam int unsigned NumTargets    = 4;
  localparam int unsigned NumPulses     = 12;
  // Full run is a little under 500 cycles
  localparam int unsigned TimeoutCycles = 2000;
  localparam logic [3:0]  MtimecmpNum   = 4'd8;

  logic                clk_i;
  logic                ndmreset_n;
  logic                req_valid_i;
  logic [31:0]         req_addr_i;
  logic                cfg_we_i;
  logic [3:0]          cfg_addr_i;
  logic [31:0]         cfg_wdata_i;
  logic                rtc_i;
  logic [NumHarts-1:0] dbg_req_i;
  logic                hit_o;
  logic                miss_o;
  logic [1:0]          target_o;
  logic [31:0]         mtime_o;
  logic                timer_irq_o;
  logic [NumHarts-1:0] dbg_req_o;

  // Reference model state
  logic [15:0] lfsr_q = 16'd88;
  logic [31:0] ref_start [NumTargets];
  logic [31:0] ref_end   [NumTargets];
  logic [31:0] ref_cmp;
  logic [3:0]  exp_q [$];

  soc_ctrl_top u_soc_ctrl_top (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_valid_i ( req_valid_i ),
    .req_addr_i  ( req_addr_i  ),
    .hit_o       ( hit_o       ),
    .miss_o      ( miss_o      ),
    .target_o    ( target_o    ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .rtc_i       ( rtc_i       ),
    .mtime_o     ( mtime_o     ),
    .timer_irq_o ( timer_irq_o ),
    .dbg_req_i   ( dbg_req_i   ),
    .dbg_req_o   ( dbg_req_o   )
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // ----------------------------------------------------------
  // Random source and reference model
  // ----------------------------------------------------------
  // Polynomial x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [31:0] lfsr_bits(input int unsigned n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      bits   = {bits[30:0], fb};
    end
    return bits;
  endfunction

  // Lowest matching rule wins with the end bound exclusive
  function automatic logic [2:0] decode_ref(input logic [31:0] addr);
    for (int i = 0; i < NumTargets; i++) begin
      if (addr >= ref_start[i] && addr < ref_end[i]) begin
        return {1'b1, 2'(i)};
      end
    end
    return 3'b000;
  endfunction

  // Half the addresses land inside a rule and half anywhere
  function automatic logic [31:0] rand_addr();
    logic [1:0] k;
    if (lfsr_bits(1) == 32'd1) begin
      k = 2'(lfsr_bits(2));
      if (ref_start[k] < ref_end[k]) begin
        return ref_start[k] + (lfsr_bits(32) % (ref_end[k] - ref_start[k]));
      end
    end
    return lfsr_bits(32);
  endfunction

  task automatic check_eq(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("[ERROR] %0t %s: expected 0x%0h, actual 0x%0h", $time, name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // ----------------------------------------------------------
  // Stimulus tasks
  // ----------------------------------------------------------
  task automatic next_cycle();
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    cfg_we_i    <= 1'b0;
  endtask

  task automatic send_req(input logic [31:0] addr);
    logic [2:0] res;
    res = decode_ref(addr);
    next_cycle();
    req_valid_i <= 1'b1;
    req_addr_i  <= addr;
    exp_q.push_back({1'b1, res});
  endtask

  task automatic cfg_write(input logic [3:0] num, input logic [31:0] data);
    next_cycle();
    cfg_we_i    <= 1'b1;
    cfg_addr_i  <= num;
    cfg_wdata_i <= data;
  endtask

  task automatic write_rule(input int unsigned k, input logic [31:0] lo, input logic [31:0] hi);
    cfg_write(4'(2 * k), lo);
    cfg_write(4'(2 * k + 1), hi);
    ref_start[k] = lo;
    ref_end[k]   = hi;
  endtask

  // ----------------------------------------------------------
  // Decoder result comparison and timeout
  // ----------------------------------------------------------
  // Entries hold valid, hit and target for the cycle after the drive
  initial begin
    logic [3:0] pending;
    pending = '0;
    forever begin
      @(negedge clk_i);
      check_eq("hit_o", 32'(hit_o), 32'(pending[3] & pending[2]));
      check_eq("miss_o", 32'(miss_o), 32'(pending[3] & ~pending[2]));
      if (pending[3] && pending[2]) begin
        check_eq("target_o", 32'(target_o), 32'(pending[1:0]));
      end
      if (exp_q.size() != 0) begin
        pending = exp_q.pop_front();
      end else begin
        pending = '0;
      end
    end
  end

  initial begin
    int unsigned cycles;
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Run did not finish within %0d cycles", TimeoutCycles);
    $display("TESTS FAILED");
    $fatal(1, "Timeout");
  end

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    logic [NumHarts-1:0] hart_req;
    logic [31:0]         gap;
    logic [31:0]         exp_mtime;
    ndmreset_n  <= 1'b0;
    req_valid_i <= 1'b0;
    req_addr_i  <= '0;
    cfg_we_i    <= 1'b0;
    cfg_addr_i  <= '0;
    cfg_wdata_i <= '0;
    rtc_i       <= 1'b0;
    dbg_req_i   <= '0;
    // Default map and compare after reset
    ref_start[0] = 32'h0001_0000;
    ref_end[0]   = 32'h0002_0000;
    ref_start[1] = 32'h1000_0000;
    ref_end[1]   = 32'h1010_0000;
    ref_start[2] = 32'h2000_0000;
    ref_end[2]   = 32'h2100_0000;
    ref_start[3] = 32'h0000_0000;
    ref_end[3]   = 32'h0000_1000;
    ref_cmp      = '1;

    for (int unsigned i = 0; i < ResetCycles; i++) begin
      next_cycle();
      if (i == ResetCycles - 1) begin
        ndmreset_n <= 1'b1;
      end
      @(negedge clk_i);
      check_eq("timer_irq_o", 32'(timer_irq_o), 32'd0);
      check_eq("mtime_o", mtime_o, 32'd0);
    end

    // Debug hold-off with the boundary cycle left unchecked
    for (int unsigned k = 1; k <= HoldOffCycles + 10; k++) begin
      hart_req = NumHarts'(lfsr_bits(NumHarts));
      if (hart_req == '0) begin
        hart_req = NumHarts'(1);
      end
      next_cycle();
      dbg_req_i <= hart_req;
      @(negedge clk_i);
      if (k < HoldOffCycles) begin
        check_eq("dbg_req_o", 32'(dbg_req_o), 32'd0);
      end else if (k > HoldOffCycles) begin
        check_eq("dbg_req_o", 32'(dbg_req_o), 32'(hart_req));
      end
      check_eq("mtime_o", mtime_o, 32'd0);
    end

    // Default map with back-to-back requests, rule edges and gaps
    repeat (150) send_req(rand_addr());
    for (int k = 0; k < NumTargets; k++) begin
      send_req(ref_start[k]);
      send_req(ref_end[k] - 32'd1);
      send_req(ref_end[k]);
    end
    repeat (20) begin
      send_req(rand_addr());
      gap = lfsr_bits(2) + 32'd1;
      repeat (gap) next_cycle();
    end

    // Rule 2 takes over rule 0 while rule 0 goes empty and rule 3 overlaps rule 2
    write_rule(2, 32'h0001_0000, 32'h0002_0000);
    write_rule(0, 32'h0001_8000, 32'h0001_0000);
    write_rule(3, 32'h0000_0000, 32'h0001_4000);
    cfg_write(4'd9, 32'hdead_beef);
    cfg_write(4'd15, 32'h0000_0000);
    send_req(32'h0001_0000);
    send_req(32'h0001_3fff);
    send_req(32'h0001_4000);
    send_req(32'h0001_8000);
    send_req(32'h0001_ffff);
    send_req(32'h0002_0000);
    send_req(32'h0000_0fff);
    send_req(32'h2000_0000);
    repeat (52) send_req(rand_addr());

    // Timebase counts every second rtc_i rising edge
    cfg_write(MtimecmpNum, 32'd5);
    ref_cmp = 32'd5;
    for (int unsigned n = 1; n <= NumPulses; n++) begin
      repeat (4) begin
        next_cycle();
        rtc_i <= 1'b1;
      end
      repeat (4) begin
        next_cycle();
        rtc_i <= 1'b0;
      end
      @(negedge clk_i);
      exp_mtime = n / 2;
      check_eq("mtime_o", mtime_o, exp_mtime);
      check_eq("timer_irq_o", 32'(timer_irq_o), 32'(exp_mtime >= ref_cmp));
    end
    repeat (8) next_cycle();
    @(negedge clk_i);
    check_eq("mtime_o", mtime_o, 32'(NumPulses / 2));

    cfg_write(MtimecmpNum, 32'd100);
    ref_cmp = 32'd100;
    repeat (2) next_cycle();
    @(negedge clk_i);
    check_eq("timer_irq_o", 32'(timer_irq_o), 32'd0);

    repeat (3) next_cycle();
    @(negedge clk_i);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* testbench/soc_ctrl_props.sv */
module soc_ctrl_props (
  input logic clk_i,
  input logic ndmreset_n,
  input logic req_valid_i,
  input logic hit_o,
  input logic miss_o
);

  // ----------------------------------------------------------
  // Decoder result protocol
  // ----------------------------------------------------------
  // Never both at once
  a_hit_miss_excl : assert property (
    @(posedge clk_i) disable iff (!ndmreset_n) !(hit_o && miss_o)
  ) else $error("hit_o and miss_o high in the same cycle");

  // Each request gets exactly one answer a cycle later
  a_req_answered : assert property (
    @(posedge clk_i) disable iff (!ndmreset_n) req_valid_i |=> (hit_o != miss_o)
  ) else $error("Request without exactly one of hit_o or miss_o");

  // Idle cycle leaves both low
  a_idle_quiet : assert property (
    @(posedge clk_i) disable iff (!ndmreset_n) !req_valid_i |=> !(hit_o || miss_o)
  ) else $error("Result seen after a cycle without request");

endmodule

bind addr_decoder soc_ctrl_props u_soc_ctrl_props (
  .clk_i       ( clk_i       ),
  .ndmreset_n  ( ndmreset_n  ),
  .req_valid_i ( req_valid_i ),
  .hit_o       ( hit_o       ),
  .miss_o      ( miss_o      )
);

/* hdl/soc_ctrl_top.sv */
module soc_ctrl_top #(
  parameter int unsigned NumHarts      = 2,
  parameter int unsigned HoldOffCycles = 20
) (
  input  logic                                  clk_i,
  input  logic                                  ndmreset_n,

  // Address requests
  input  logic                                  req_valid_i,
  input  subsys_pkg::addr_t                     req_addr_i,
  output logic                                  hit_o,
  output logic                                  miss_o,
  output subsys_pkg::tgt_idx_t                  target_o,

  // Configuration writes
  input  logic                                  cfg_we_i,
  input  logic [subsys_pkg::CfgAddrWidth-1:0]   cfg_addr_i,
  input  subsys_pkg::addr_t                     cfg_wdata_i,

  // Timebase
  input  logic                                  rtc_i,
  output subsys_pkg::time_t                     mtime_o,
  output logic                                  timer_irq_o,

  // Debug requests per hart
  input  logic [NumHarts-1:0]                   dbg_req_i,
  output logic [NumHarts-1:0]                   dbg_req_o
);

  import subsys_pkg::*;

  rule_t [NumTargets-1:0] rules;
  time_t                  mtimecmp;

  // ----------------------------------------------------------
  // Configuration registers
  // ----------------------------------------------------------
  map_cfg_regs u_map_cfg_regs (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .rules_o     ( rules       ),
    .mtimecmp_o  ( mtimecmp    )
  );

  // ----------------------------------------------------------
  // Address decoder
  // ----------------------------------------------------------
  addr_decoder u_addr_decoder (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_valid_i ( req_valid_i ),
    .req_addr_i  ( req_addr_i  ),
    .rules_i     ( rules       ),
    .hit_o       ( hit_o       ),
    .miss_o      ( miss_o      ),
    .target_o    ( target_o    )
  );

  // ----------------------------------------------------------
  // Real-time timebase
  // ----------------------------------------------------------
  rtc_timebase u_rtc_timebase (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .mtimecmp_i  ( mtimecmp    ),
    .mtime_o     ( mtime_o     ),
    .timer_irq_o ( timer_irq_o )
  );

  // ----------------------------------------------------------
  // Debug request hold-off
  // ----------------------------------------------------------
  debug_holdoff #(
    .NumHarts      ( NumHarts      ),
    .HoldOffCycles ( HoldOffCycles )
  ) u_debug_holdoff (
    .clk_i         ( clk_i         ),
    .ndmreset_n    ( ndmreset_n    ),
    .dbg_req_i     ( dbg_req_i     ),
    .dbg_req_o     ( dbg_req_o     )
  );

endmodule

/* hdl/rtc_timebase.sv */
module rtc_timebase (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  input  logic              rtc_i,
  input  subsys_pkg::time_t mtimecmp_i,
  output subsys_pkg::time_t mtime_o,
  output logic              timer_irq_o
);

  import subsys_pkg::*;

  logic  rtc_s1_q;
  logic  rtc_s2_q;
  logic  rtc_prev_q;
  logic  rtc_rise;
  logic  half_q;
  logic  tick;
  time_t mtime_q;
  logic  irq_q;

  // ----------------------------------------------------------
  // Synchronizer and edge detect
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_s1_q   <= 1'b0;
      rtc_s2_q   <= 1'b0;
      rtc_prev_q <= 1'b0;
    end else begin
      rtc_s1_q   <= rtc_i;
      rtc_s2_q   <= rtc_s1_q;
      rtc_prev_q <= rtc_s2_q;
    end
  end

  assign rtc_rise = rtc_s2_q & ~rtc_prev_q;

  // Divide by two: toggle on every edge, tick on every second one
  assign tick = rtc_rise & half_q;

  // ----------------------------------------------------------
  // Machine timer and compare
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      half_q  <= 1'b0;
      mtime_q <= '0;
    end else begin
      if (rtc_rise) begin
        half_q <= ~half_q;
      end
      if (tick) begin
        mtime_q <= mtime_q + time_t'(1);
      end
    end
  end

  // Follows a change of either operand one cycle later
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= (mtime_q >= mtimecmp_i);
    end
  end

  assign mtime_o     = mtime_q;
  assign timer_irq_o = irq_q;

endmodule

/* hdl/debug_holdoff.sv */
module debug_holdoff #(
  parameter int unsigned NumHarts      = 2,
  parameter int unsigned HoldOffCycles = 20
) (
  input  logic                clk_i,
  input  logic                ndmreset_n,
  input  logic [NumHarts-1:0] dbg_req_i,
  output logic [NumHarts-1:0] dbg_req_o
);

  // Counter must hold HoldOffCycles itself
  localparam int unsigned CntWidth =
    (HoldOffCycles > 0) ? $clog2(HoldOffCycles + 1) : 1;

  logic [CntWidth-1:0] cnt_q;
  logic                holdoff;

  assign holdoff = (cnt_q != '0);

  // ----------------------------------------------------------
  // Hold-off counter
  // ----------------------------------------------------------
  // Gives boot code time to set up before a debug halt lands
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= CntWidth'(HoldOffCycles);
    end else if (holdoff) begin
      cnt_q <= cnt_q - CntWidth'(1);
    end
  end

  // Requests pass straight through once the count runs out
  assign dbg_req_o = holdoff ? '0 : dbg_req_i;

endmodule

/* hdl/addr_decoder.sv */
module addr_decoder (
  input  logic                                             clk_i,
  input  logic                                             ndmreset_n,
  input  logic                                             req_valid_i,
  input  subsys_pkg::addr_t                                req_addr_i,
  input  subsys_pkg::rule_t [subsys_pkg::NumTargets-1:0]   rules_i,
  output logic                                             hit_o,
  output logic                                             miss_o,
  output subsys_pkg::tgt_idx_t                             target_o
);

  import subsys_pkg::*;

  logic [NumTargets-1:0] rule_hit;
  logic                  match;
  tgt_idx_t              match_idx;

  logic     hit_q;
  logic     miss_q;
  tgt_idx_t target_q;

  // ----------------------------------------------------------
  // Rule match
  // ----------------------------------------------------------
  // An empty or inverted range never matches
  always_comb begin
    for (int i = 0; i < NumTargets; i++) begin
      rule_hit[i] = (rules_i[i].start_addr < rules_i[i].end_addr) &&
                    (req_addr_i >= rules_i[i].start_addr) &&
                    (req_addr_i <  rules_i[i].end_addr);
    end
  end

  // Walk downwards so the lowest index wins on overlap
  always_comb begin
    match     = 1'b0;
    match_idx = '0;
    for (int i = NumTargets - 1; i >= 0; i--) begin
      if (rule_hit[i]) begin
        match     = 1'b1;
        match_idx = tgt_idx_t'(i);
      end
    end
  end

  // ----------------------------------------------------------
  // Result stage
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      hit_q  <= 1'b0;
      miss_q <= 1'b0;
    end else begin
      hit_q  <= req_valid_i & match;
      miss_q <= req_valid_i & ~match;
    end
  end

  // Target only matters alongside hit
  always_ff @(posedge clk_i) begin
    if (req_valid_i && match) begin
      target_q <= match_idx;
    end
  end

  assign hit_o    = hit_q;
  assign miss_o   = miss_q;
  assign target_o = target_q;

endmodule

/* hdl/map_cfg_regs.sv */
module map_cfg_regs (
  input  logic                                             clk_i,
  input  logic                                             ndmreset_n,
  input  logic                                             cfg_we_i,
  input  logic [subsys_pkg::CfgAddrWidth-1:0]              cfg_addr_i,
  input  subsys_pkg::addr_t                                cfg_wdata_i,
  output subsys_pkg::rule_t [subsys_pkg::NumTargets-1:0]   rules_o,
  output subsys_pkg::time_t                                mtimecmp_o
);

  import subsys_pkg::*;

  // Rule bounds occupy the lowest register numbers
  localparam int unsigned NumRuleRegs = 2 * NumTargets;

  rule_t [NumTargets-1:0] rules_q;
  time_t                  mtimecmp_q;

  logic     rule_we;
  logic     rule_end_sel;
  tgt_idx_t rule_idx;
  logic     mtimecmp_we;

  // ----------------------------------------------------------
  // Write decode
  // ----------------------------------------------------------
  always_comb begin
    rule_we      = 1'b0;
    mtimecmp_we  = 1'b0;
    rule_idx     = cfg_addr_i[TgtIdxWidth:1];
    rule_end_sel = cfg_addr_i[0];

    if (cfg_we_i) begin
      if (cfg_addr_i < CfgAddrWidth'(NumRuleRegs)) begin
        rule_we = 1'b1;
      end else if (cfg_addr_i == MtimecmpReg) begin
        mtimecmp_we = 1'b1;
      end
      // Higher numbers fall through without effect
    end
  end

  // ----------------------------------------------------------
  // Register storage
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rules_q <= DefaultRules;
    end else if (rule_we) begin
      if (rule_end_sel) begin
        rules_q[rule_idx].end_addr <= cfg_wdata_i;
      end else begin
        rules_q[rule_idx].start_addr <= cfg_wdata_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtimecmp_q <= MtimecmpReset;
    end else if (mtimecmp_we) begin
      // Address and time words share one width here
      mtimecmp_q <= time_t'(cfg_wdata_i);
    end
  end

  // New values show up the cycle after the write strobe
  assign rules_o    = rules_q;
  assign mtimecmp_o = mtimecmp_q;

endmodule

/* hdl/subsys_pkg.sv */
package subsys_pkg;

  // ----------------------------------------------------------
  // Address map
  // ----------------------------------------------------------
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned NumTargets  = 4;
  localparam int unsigned TgtIdxWidth = $clog2(NumTargets);

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [TgtIdxWidth-1:0] tgt_idx_t;

  // Start is inclusive, end is exclusive
  typedef struct packed {
    addr_t start_addr;
    addr_t end_addr;
  } rule_t;

  // Targets are ROM, L2, peripherals and debug, in that order
  localparam rule_t [NumTargets-1:0] DefaultRules = '{
    0: '{start_addr: 32'h0001_0000, end_addr: 32'h0002_0000},
    1: '{start_addr: 32'h1000_0000, end_addr: 32'h1010_0000},
    2: '{start_addr: 32'h2000_0000, end_addr: 32'h2100_0000},
    3: '{start_addr: 32'h0000_0000, end_addr: 32'h0000_1000}
  };

  // ----------------------------------------------------------
  // Configuration register numbering
  // ----------------------------------------------------------
  // Register 2k is the start of rule k, 2k+1 its end
  localparam int unsigned CfgAddrWidth = 4;

  localparam logic [CfgAddrWidth-1:0] MtimecmpReg = 4'd8;

  // ----------------------------------------------------------
  // Machine timer
  // ----------------------------------------------------------
  localparam int unsigned TimeWidth = 32;

  typedef logic [TimeWidth-1:0] time_t;

  // All ones keeps the timer interrupt quiet until programmed
  localparam time_t MtimecmpReset = '1;

endpackage
